/* logic/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Word and address widths
`define CORE_DATA_WIDTH 16

`define CORE_ADDR_WIDTH 12

`define CORE_OPCODE_WIDTH 4

// First fetch address
`define CORE_RESET_PC 0

// Sequence tag carried by each request source
`define CORE_SRC_TAG_WIDTH 2

// Memory tag is the source tag with the source bit on top
`define CORE_MEM_TAG_WIDTH (`CORE_SRC_TAG_WIDTH + 1)

`define CORE_MEM_SRC_BIT `CORE_SRC_TAG_WIDTH

`endif

/* logic/core_pkg.sv */
`include "core_defines.svh"
`default_nettype none

package core_pkg;

    typedef logic [`CORE_DATA_WIDTH-1:0] word_t;

    typedef logic [`CORE_ADDR_WIDTH-1:0] addr_t;

    typedef logic [`CORE_SRC_TAG_WIDTH-1:0] src_tag_t;

    typedef logic [`CORE_MEM_TAG_WIDTH-1:0] mem_tag_t;

    // Unlisted opcodes decode as no-operation
    typedef enum logic [`CORE_OPCODE_WIDTH-1:0] {
        OP_ADDI = 4'h1,
        OP_LD   = 4'h2,
        OP_ST   = 4'h3,
        OP_HALT = 4'hf
    } opcode_t;

    typedef struct packed {
        opcode_t opcode;
        addr_t   operand;
    } instr_t;

    // Source bit of the memory tag
    localparam logic SRC_FETCH = 1'b0;
    localparam logic SRC_DATA  = 1'b1;

endpackage

`default_nettype wire

/* logic/mem_if.sv */
`default_nettype none

interface mem_req_if #(
    parameter type tag_t = core_pkg::src_tag_t
);
    import core_pkg::*;

    logic  valid;
    logic  rw;
    addr_t addr;
    word_t data;
    tag_t  tag;
    logic  ready;

    modport requester (
        output valid,
        output rw,
        output addr,
        output data,
        output tag,
        input  ready
    );

    modport receiver (
        input  valid,
        input  rw,
        input  addr,
        input  data,
        input  tag,
        output ready
    );

endinterface

interface mem_rsp_if #(
    parameter type tag_t = core_pkg::src_tag_t
);
    import core_pkg::*;

    logic  valid;
    word_t data;
    tag_t  tag;
    logic  ready;

    modport responder (
        output valid,
        output data,
        output tag,
        input  ready
    );

    modport consumer (
        input  valid,
        input  data,
        input  tag,
        output ready
    );

endinterface

`default_nettype wire

/* logic/core_fetch.sv */
`include "core_defines.svh"
`default_nettype none

module core_fetch (
    input  wire               clk,
    input  wire               rst_n,
    mem_req_if.requester      icache_req,
    mem_rsp_if.consumer       icache_rsp,
    output logic              instr_valid,
    output core_pkg::instr_t  instr,
    input  wire               instr_take,
    input  wire               halted
);
    import core_pkg::*;

    addr_t    pc;
    src_tag_t fetch_tag;
    logic     req_valid;
    logic     outstanding;
    logic     buf_valid;
    instr_t   buf_instr;
    logic     req_fire;
    logic     rsp_hit;
    logic     can_issue;

    assign req_fire  = req_valid && icache_req.ready;
    assign rsp_hit   = icache_rsp.valid && outstanding && (icache_rsp.tag == fetch_tag);
    // Buffer must be free, or freed by this cycle's take
    assign can_issue = !halted && !req_valid && !outstanding && (!buf_valid || instr_take);

    assign icache_req.valid = req_valid;
    assign icache_req.rw    = 1'b0;
    assign icache_req.addr  = pc;
    assign icache_req.data  = '0;
    assign icache_req.tag   = fetch_tag;
    assign icache_rsp.ready = 1'b1;

    assign instr_valid = buf_valid;
    assign instr       = buf_instr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= addr_t'(`CORE_RESET_PC);
            fetch_tag   <= '0;
            req_valid   <= 1'b0;
            outstanding <= 1'b0;
            buf_valid   <= 1'b0;
        end else begin
            if (can_issue) begin
                req_valid <= 1'b1;
            end
            if (req_fire) begin
                req_valid   <= 1'b0;
                outstanding <= 1'b1;
                pc          <= pc + 1'b1;
            end
            if (instr_take) begin
                buf_valid <= 1'b0;
            end
            // Late responses after halt are consumed and dropped
            if (rsp_hit) begin
                outstanding <= 1'b0;
                fetch_tag   <= fetch_tag + 1'b1;
                if (!halted) begin
                    buf_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_hit) begin
            buf_instr <= instr_t'(icache_rsp.data);
        end
    end

endmodule

`default_nettype wire

/* logic/core_execute.sv */
`default_nettype none

module core_execute (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    instr_valid,
    input  wire core_pkg::instr_t  instr,
    output logic                   instr_take,
    mem_req_if.requester           dcache_req,
    mem_rsp_if.consumer            dcache_rsp,
    output logic                   halted
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        EX_IDLE,
        EX_WAIT_LD,
        EX_WAIT_ST,
        EX_HALTED
    } ex_state_t;

    ex_state_t state;
    word_t     acc;
    src_tag_t  data_tag;
    logic      req_valid;
    logic      req_rw;
    addr_t     req_addr;
    word_t     req_data;
    logic      req_fire;
    logic      rsp_hit;

    assign instr_take = instr_valid && (state == EX_IDLE);
    assign halted     = (state == EX_HALTED);
    assign req_fire   = req_valid && dcache_req.ready;
    assign rsp_hit    = dcache_rsp.valid && (dcache_rsp.tag == data_tag);

    assign dcache_req.valid = req_valid;
    assign dcache_req.rw    = req_rw;
    assign dcache_req.addr  = req_addr;
    assign dcache_req.data  = req_data;
    assign dcache_req.tag   = data_tag;
    assign dcache_rsp.ready = 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= EX_IDLE;
            acc       <= '0;
            data_tag  <= '0;
            req_valid <= 1'b0;
        end else begin
            case (state)
                EX_IDLE: begin
                    if (instr_valid) begin
                        case (instr.opcode)
                            OP_ADDI: acc <= acc + word_t'(instr.operand);
                            OP_LD: begin
                                req_valid <= 1'b1;
                                state     <= EX_WAIT_LD;
                            end
                            OP_ST: begin
                                req_valid <= 1'b1;
                                state     <= EX_WAIT_ST;
                            end
                            OP_HALT: state <= EX_HALTED;
                            default: ;
                        endcase
                    end
                end
                EX_WAIT_LD: begin
                    if (req_fire) begin
                        req_valid <= 1'b0;
                    end
                    // Load completes on its own response only
                    if (rsp_hit) begin
                        acc      <= dcache_rsp.data;
                        data_tag <= data_tag + 1'b1;
                        state    <= EX_IDLE;
                    end
                end
                EX_WAIT_ST: begin
                    if (req_fire) begin
                        req_valid <= 1'b0;
                        data_tag  <= data_tag + 1'b1;
                        state     <= EX_IDLE;
                    end
                end
                default: ;
            endcase
        end
    end

    // Request payload captured at take
    always_ff @(posedge clk) begin
        if (instr_take) begin
            req_rw   <= (instr.opcode == OP_ST);
            req_addr <= instr.operand;
            req_data <= acc;
        end
    end

endmodule

`default_nettype wire

/* logic/mem_unit.sv */
`include "core_defines.svh"
`default_nettype none

module mem_unit (
    input  wire           clk,
    input  wire           rst_n,
    mem_req_if.receiver   icache_req,
    mem_rsp_if.responder  icache_rsp,
    mem_req_if.receiver   dcache_req,
    mem_rsp_if.responder  dcache_rsp,
    mem_req_if.requester  mem_req,
    mem_rsp_if.consumer   mem_rsp
);
    import core_pkg::*;

    logic prio_data;
    logic locked;
    logic sel_locked;
    logic sel_data;
    logic req_fire;
    logic rsp_src;

    // Grant stays put while the port is stalled
    assign sel_data = locked ? sel_locked
                             : dcache_req.valid && (!icache_req.valid || prio_data);

    assign req_fire = mem_req.valid && mem_req.ready;

    assign mem_req.valid = icache_req.valid || dcache_req.valid;
    assign mem_req.rw    = sel_data ? dcache_req.rw : icache_req.rw;
    assign mem_req.addr  = sel_data ? dcache_req.addr : icache_req.addr;
    assign mem_req.data  = sel_data ? dcache_req.data : icache_req.data;
    assign mem_req.tag   = sel_data ? {SRC_DATA, dcache_req.tag}
                                    : {SRC_FETCH, icache_req.tag};

    assign icache_req.ready = mem_req.ready && !sel_data;
    assign dcache_req.ready = mem_req.ready && sel_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prio_data  <= 1'b0;
            locked     <= 1'b0;
            sel_locked <= 1'b0;
        end else begin
            locked     <= mem_req.valid && !mem_req.ready;
            sel_locked <= sel_data;
            if (req_fire) begin
                prio_data <= !prio_data;
            end
        end
    end

    // Responses steered by the source bit, which is stripped here
    assign rsp_src = mem_rsp.tag[`CORE_MEM_SRC_BIT];

    assign icache_rsp.valid = mem_rsp.valid && (rsp_src == SRC_FETCH);
    assign icache_rsp.data  = mem_rsp.data;
    assign icache_rsp.tag   = mem_rsp.tag[`CORE_MEM_SRC_BIT-1:0];

    assign dcache_rsp.valid = mem_rsp.valid && (rsp_src == SRC_DATA);
    assign dcache_rsp.data  = mem_rsp.data;
    assign dcache_rsp.tag   = mem_rsp.tag[`CORE_MEM_SRC_BIT-1:0];

    assign mem_rsp.ready = (rsp_src == SRC_DATA) ? dcache_rsp.ready : icache_rsp.ready;

endmodule

`default_nettype wire

/* logic/core_top.sv */
`default_nettype none

module core_top (
    input  wire                      clk,
    input  wire                      rst_n,

    output wire                      mem_req_valid,
    output wire                      mem_req_rw,
    output wire core_pkg::addr_t     mem_req_addr,
    output wire core_pkg::word_t     mem_req_data,
    output wire core_pkg::mem_tag_t  mem_req_tag,
    input  wire                      mem_req_ready,

    input  wire                      mem_rsp_valid,
    input  wire core_pkg::word_t     mem_rsp_data,
    input  wire core_pkg::mem_tag_t  mem_rsp_tag,
    output wire                      mem_rsp_ready,

    output wire                      busy
);
    import core_pkg::*;

    logic   instr_valid;
    instr_t instr;
    logic   instr_take;
    logic   halted;

    mem_req_if #(.tag_t(src_tag_t)) icache_req ();
    mem_rsp_if #(.tag_t(src_tag_t)) icache_rsp ();
    mem_req_if #(.tag_t(src_tag_t)) dcache_req ();
    mem_rsp_if #(.tag_t(src_tag_t)) dcache_rsp ();

    // External port side
    mem_req_if #(.tag_t(mem_tag_t)) mem_req ();
    mem_rsp_if #(.tag_t(mem_tag_t)) mem_rsp ();

    assign mem_req_valid = mem_req.valid;
    assign mem_req_rw    = mem_req.rw;
    assign mem_req_addr  = mem_req.addr;
    assign mem_req_data  = mem_req.data;
    assign mem_req_tag   = mem_req.tag;
    assign mem_req.ready = mem_req_ready;

    assign mem_rsp.valid = mem_rsp_valid;
    assign mem_rsp.data  = mem_rsp_data;
    assign mem_rsp.tag   = mem_rsp_tag;
    assign mem_rsp_ready = mem_rsp.ready;

    assign busy = !halted;

    core_fetch u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .icache_req  (icache_req),
        .icache_rsp  (icache_rsp),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_take  (instr_take),
        .halted      (halted)
    );

    core_execute u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_take  (instr_take),
        .dcache_req  (dcache_req),
        .dcache_rsp  (dcache_rsp),
        .halted      (halted)
    );

    mem_unit u_mem_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .icache_req  (icache_req),
        .icache_rsp  (icache_rsp),
        .dcache_req  (dcache_req),
        .dcache_rsp  (dcache_rsp),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp)
    );

endmodule

`default_nettype wire

/* verification/core_props.sv */
`include "core_defines.svh"
`default_nettype none

module core_props (
    input wire                     clk,
    input wire                     rst_n,
    input wire                     mem_req_valid,
    input wire                     mem_req_rw,
    input wire core_pkg::addr_t    mem_req_addr,
    input wire core_pkg::word_t    mem_req_data,
    input wire core_pkg::mem_tag_t mem_req_tag,
    input wire                     mem_req_ready,
    input wire                     busy
);
    import core_pkg::*;

    int prop_failures = 0;

    // Stalled request holds every field
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_rw)
            && $stable(mem_req_addr) && $stable(mem_req_data) && $stable(mem_req_tag))
    else begin
        $error("memory request changed while stalled");
        prop_failures++;
    end

    write_from_data: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && mem_req_rw |-> mem_req_tag[`CORE_MEM_SRC_BIT] == SRC_DATA)
    else begin
        $error("write request without the data source bit");
        prop_failures++;
    end

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n && $past(!rst_n) |-> !mem_req_valid)
    else begin
        $error("request valid while held in reset");
        prop_failures++;
    end

    // Halt is final
    halt_sticks: assert property (@(posedge clk) disable iff (!rst_n) !busy |=> !busy)
    else begin
        $error("busy rose again after halt");
        prop_failures++;
    end

endmodule

bind core_top core_props u_props (.*);

`default_nettype wire

/* verification/core_tb.sv */
`include "core_defines.svh"
`default_nettype none

module core_tb;
    import core_pkg::*;

    localparam int NUM_INSTR   = 12;
    localparam int CYCLE_LIMIT = 40 * NUM_INSTR;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     mem_req_valid;
    logic     mem_req_rw;
    addr_t    mem_req_addr;
    word_t    mem_req_data;
    mem_tag_t mem_req_tag;
    logic     mem_req_ready;
    logic     mem_rsp_valid;
    word_t    mem_rsp_data;
    mem_tag_t mem_rsp_tag;
    logic     mem_rsp_ready;
    logic     busy;

    word_t       mem [0:4095];
    logic        pend_valid [0:7];
    word_t       pend_data [0:7];
    int          pend_wait [0:7];
    addr_t       exp_addr [$];
    word_t       exp_data [$];
    logic [15:0] lfsr = 16'd68;
    int          errors = 0;
    int          cycles = 0;
    int          num_stores = 0;
    int          stores_seen = 0;
    int          reads = 0;
    int          rsps = 0;
    int          accepted = 0;
    int          quiet_mark;

    core_top u_dut (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            errors++;
            $display("Timeout: the core did not halt and drain within %0d cycles", CYCLE_LIMIT);
            report_and_finish();
        end
    end

    function automatic logic next_random_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    // Pattern depends on every address bit
    function automatic word_t fill_word(addr_t a);
        return {a, 4'h0} ^ {4'h0, a} ^ 16'hc3a5;
    endfunction

    function automatic word_t assemble(opcode_t op, addr_t operand);
        return {op, operand};
    endfunction

    function automatic string store_test(int idx);
        if (idx == 1) return "addi_st";
        if (idx == 2) return "ld_addi_st";
        return "out_of_order_st";
    endfunction

    function automatic logic any_pending();
        logic p;
        p = 1'b0;
        for (int t = 0; t < 8; t++) begin
            p = p | pend_valid[t];
        end
        return p;
    endfunction

    task automatic load_program();
        for (int a = 0; a < 4096; a++) begin
            mem[a] = fill_word(addr_t'(a));
        end
        mem[0]  = assemble(OP_ADDI, 12'h005);
        mem[1]  = assemble(OP_ADDI, 12'h123);
        mem[2]  = assemble(OP_ST, 12'h200);
        mem[3]  = assemble(OP_LD, 12'h100);
        mem[4]  = assemble(OP_ADDI, 12'h007);
        mem[5]  = assemble(OP_ST, 12'h201);
        mem[6]  = assemble(OP_LD, 12'h105);
        mem[7]  = assemble(OP_ST, 12'h202);
        mem[8]  = assemble(OP_ADDI, 12'hfff);
        mem[9]  = 16'h0000;
        mem[10] = assemble(OP_ST, 12'h203);
        mem[11] = assemble(OP_HALT, 12'h000);
    endtask

    // Accumulator model, one expected word per store
    task automatic build_expected();
        word_t  acc;
        instr_t ins;
        acc = '0;
        for (int pc = 0; pc < NUM_INSTR; pc++) begin
            ins = instr_t'(mem[pc]);
            if (ins.opcode == OP_ADDI) begin
                acc = acc + {4'h0, ins.operand};
            end else if (ins.opcode == OP_LD) begin
                acc = mem[ins.operand];
            end else if (ins.opcode == OP_ST) begin
                exp_addr.push_back(ins.operand);
                exp_data.push_back(acc);
            end
        end
        num_stores = exp_addr.size();
    endtask

    task automatic take_request();
        logic  b1;
        logic  b0;
        addr_t ea;
        word_t ed;
        accepted++;
        if (accepted == 1) begin
            assert (!mem_req_rw && mem_req_addr == '0
                    && mem_req_tag[`CORE_MEM_SRC_BIT] == SRC_FETCH) else begin
                errors++;
                $display("[FAIL] reset_state expected fetch read of 000 actual rw %b addr %h tag %h",
                         mem_req_rw, mem_req_addr, mem_req_tag);
            end
        end
        if (mem_req_rw) begin
            mem[mem_req_addr] = mem_req_data;
            stores_seen++;
            assert (exp_addr.size() > 0) else begin
                errors++;
                $display("Store to %h arrived after every expected store was seen", mem_req_addr);
            end
            if (exp_addr.size() > 0) begin
                ea = exp_addr.pop_front();
                ed = exp_data.pop_front();
                assert (mem_req_addr == ea && mem_req_data == ed) else begin
                    errors++;
                    $display("[FAIL] %s expected %h at %h actual %h at %h",
                             store_test(stores_seen), ed, ea, mem_req_data, mem_req_addr);
                end
            end
        end else begin
            assert (!pend_valid[mem_req_tag]) else begin
                errors++;
                $display("Read accepted with tag %h while that tag still waits", mem_req_tag);
            end
            b1 = next_random_bit();
            b0 = next_random_bit();
            pend_valid[mem_req_tag] = 1'b1;
            pend_data[mem_req_tag]  = mem[mem_req_addr];
            pend_wait[mem_req_tag]  = 1 + 2 * int'(b1) + int'(b0);
            reads++;
        end
    endtask

    // Lowest ready tag goes first, so latency decides the order
    task automatic drive_memory();
        int pick;
        pick = -1;
        for (int t = 0; t < 8; t++) begin
            if (pend_valid[t] && pend_wait[t] > 0) begin
                pend_wait[t]--;
            end
            if (pend_valid[t] && pend_wait[t] == 0 && pick < 0) begin
                pick = t;
            end
        end
        mem_req_ready = next_random_bit();
        mem_rsp_valid = (pick >= 0);
        mem_rsp_tag   = (pick >= 0) ? mem_tag_t'(pick) : '0;
        mem_rsp_data  = (pick >= 0) ? pend_data[pick] : '0;
    endtask

    task automatic sample_port();
        if (mem_rsp_valid) begin
            assert (mem_rsp_ready) else begin
                errors++;
                $display("[FAIL] rsp_ready expected 1 actual %b", mem_rsp_ready);
            end
        end
        if (mem_rsp_valid && mem_rsp_ready) begin
            pend_valid[mem_rsp_tag] = 1'b0;
            rsps++;
        end
        if (mem_req_valid && mem_req_ready) begin
            take_request();
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
        drive_memory();
        @(negedge clk);
        sample_port();
    endtask

    task automatic report_and_finish();
        int total;
        total = errors + u_dut.u_props.prop_failures;
        $display("Run ended after %0d cycles: %0d error(s), %0d of %0d stores seen",
                 cycles, total, stores_seen, num_stores);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    initial begin
        rst_n         = 1'b0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        mem_rsp_tag   = '0;
        for (int t = 0; t < 8; t++) begin
            pend_valid[t] = 1'b0;
            pend_wait[t]  = 0;
            pend_data[t]  = '0;
        end
        load_program();
        build_expected();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (busy && !mem_req_valid) else begin
            errors++;
            $display("[FAIL] reset_state expected busy 1 valid 0 actual busy %b valid %b",
                     busy, mem_req_valid);
        end
        drive_memory();
        @(negedge clk);
        sample_port();
        while (busy) begin
            step();
        end
        // Every store ahead of HALT completes before busy falls
        assert (stores_seen == num_stores) else begin
            errors++;
            $display("[FAIL] halt expected %0d stores actual %0d", num_stores, stores_seen);
        end
        while (mem_req_valid) begin
            step();
        end
        quiet_mark = accepted;
        // Window well past the worst read latency
        repeat (16) begin
            step();
        end
        assert (accepted == quiet_mark) else begin
            errors++;
            $display("A memory request was accepted after the halted core had drained");
        end
        assert (rsps == reads && !any_pending()) else begin
            errors++;
            $display("[FAIL] out_of_order expected %0d responses actual %0d", reads, rsps);
        end
        report_and_finish();
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
logic/core_pkg.sv
logic/mem_if.sv
logic/core_fetch.sv
logic/core_execute.sv
logic/mem_unit.sv
logic/core_top.sv
verification/core_props.sv
verification/core_tb.sv

/* Makefile */
SIM := obj_dir/core_sim

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f verilog.f --top-module core_tb -o core_sim

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
